// File: verilog/mips_exec_macros.svh
`ifndef MIPS_EXEC_MACROS_SVH
`define MIPS_EXEC_MACROS_SVH

// architectural register count
`define MIPS_REG_COUNT 32

// register index width for MIPS_REG_COUNT entries
`define MIPS_ADDR_W 5

// datapath word width
`define MIPS_DATA_W 32

`endif

// File: verilog/mips_exec_pkg.sv
`include "mips_exec_macros.svh"

package mips_exec_pkg;

    // R-type view of an instruction word
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_ADDR_W-1:0] rs;
        logic [`MIPS_ADDR_W-1:0] rt;
        logic [`MIPS_ADDR_W-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_fields_t;

    // I-type view with the same opcode/rs/rt positions
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_ADDR_W-1:0] rs;
        logic [`MIPS_ADDR_W-1:0] rt;
        logic [15:0]             imm;
    } i_fields_t;

    // one word decoded either way by opcode
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_word_u;

    // none doubles as the illegal marker
    typedef enum logic [3:0] {
        OP_NONE  = 4'd0,
        OP_ADDU  = 4'd1,
        OP_SUBU  = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_SLT   = 4'd6,
        OP_SLL   = 4'd7,
        OP_SRL   = 4'd8,
        OP_ADDIU = 4'd9,
        OP_ANDI  = 4'd10,
        OP_ORI   = 4'd11,
        OP_XORI  = 4'd12,
        OP_SLTI  = 4'd13,
        OP_LUI   = 4'd14
    } alu_op_e;

    // decoded instruction handed to the ALU stage
    typedef struct packed {
        alu_op_e                 op;
        logic [`MIPS_ADDR_W-1:0] rs;
        logic [`MIPS_ADDR_W-1:0] rt;
        logic [`MIPS_ADDR_W-1:0] dest;
        logic [`MIPS_DATA_W-1:0] imm;
        logic                    use_imm;
        logic                    illegal;
    } issue_t;

    // output record mirroring the write-back
    typedef struct packed {
        logic [`MIPS_ADDR_W-1:0] dest;
        logic [`MIPS_DATA_W-1:0] value;
        logic                    illegal;
    } wb_result_t;

endpackage

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps
`include "mips_exec_macros.svh"

module instr_decoder (
    input  logic                      r_clk,
    input  logic                      reset,
    input  mips_exec_pkg::instr_word_u instr,
    input  logic                      instr_valid,
    output logic                      instr_ready,
    output mips_exec_pkg::issue_t     issue,
    output logic                      issue_valid,
    input  logic                      issue_ready
);
    import mips_exec_pkg::*;

    // opcodes
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_SLTI  = 6'h0a;
    localparam logic [5:0] OPC_ANDI  = 6'h0c;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_XORI  = 6'h0e;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    // R-type funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    issue_t                  dec;
    logic [`MIPS_DATA_W-1:0] imm_sext;
    logic [`MIPS_DATA_W-1:0] imm_zext;
    logic                    load;

    // immediate variants picked per opcode below
    assign imm_sext = {{(`MIPS_DATA_W-16){instr.i_fields.imm[15]}}, instr.i_fields.imm};
    assign imm_zext = {{(`MIPS_DATA_W-16){1'b0}}, instr.i_fields.imm};

    always_comb begin
        dec         = '0;
        dec.op      = OP_NONE;
        dec.rs      = instr.r_fields.rs;
        dec.rt      = instr.r_fields.rt;
        dec.illegal = 1'b0;
        if (instr.r_fields.opcode == OPC_RTYPE) begin
            dec.dest = instr.r_fields.rd;
            // shamt rides in imm for the shifts
            dec.imm  = {{(`MIPS_DATA_W-5){1'b0}}, instr.r_fields.shamt};
            case (instr.r_fields.funct)
                FN_ADDU: dec.op = OP_ADDU;
                FN_SUBU: dec.op = OP_SUBU;
                FN_AND:  dec.op = OP_AND;
                FN_OR:   dec.op = OP_OR;
                FN_XOR:  dec.op = OP_XOR;
                FN_SLT:  dec.op = OP_SLT;
                FN_SLL:  dec.op = OP_SLL;
                FN_SRL:  dec.op = OP_SRL;
                default: dec.illegal = 1'b1;
            endcase
        end else begin
            // I-type writes rt
            dec.dest    = instr.i_fields.rt;
            dec.use_imm = 1'b1;
            case (instr.i_fields.opcode)
                OPC_ADDIU: begin
                    dec.op  = OP_ADDIU;
                    dec.imm = imm_sext;
                end
                OPC_SLTI: begin
                    dec.op  = OP_SLTI;
                    dec.imm = imm_sext;
                end
                OPC_ANDI: begin
                    dec.op  = OP_ANDI;
                    dec.imm = imm_zext;
                end
                OPC_ORI: begin
                    dec.op  = OP_ORI;
                    dec.imm = imm_zext;
                end
                OPC_XORI: begin
                    dec.op  = OP_XORI;
                    dec.imm = imm_zext;
                end
                OPC_LUI: begin
                    dec.op  = OP_LUI;
                    dec.imm = {instr.i_fields.imm, 16'h0000};
                end
                default: begin
                    dec.use_imm = 1'b0;
                    dec.illegal = 1'b1;
                end
            endcase
        end
    end

    // free slot or the held record leaves this cycle
    assign instr_ready = !issue_valid || issue_ready;
    assign load        = instr_valid && instr_ready;

    always_ff @(posedge r_clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (load) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    // record payload
    always_ff @(posedge r_clk) begin
        if (load) begin
            issue <= dec;
        end
    end

    // stalled record must not change under the ALU stage
    a_issue_stable: assert property (@(posedge r_clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue));

endmodule

// File: verilog/regfile.sv
`timescale 1ns/10ps
`include "mips_exec_macros.svh"

module regfile (
    input  logic                    r_clk,
    input  logic                    reset,
    input  logic                    r_clk_enable,
    // write strobe qualified by r_clk_enable
    input  logic                    write_control,
    // two read ports
    input  logic [`MIPS_ADDR_W-1:0] read_reg1,
    input  logic [`MIPS_ADDR_W-1:0] read_reg2,
    // single write port
    input  logic [`MIPS_ADDR_W-1:0] write_reg,
    input  logic [`MIPS_DATA_W-1:0] write_data,
    output logic [`MIPS_DATA_W-1:0] read_data1,
    output logic [`MIPS_DATA_W-1:0] read_data2
);

    logic [`MIPS_DATA_W-1:0] registers [0:`MIPS_REG_COUNT-1];
    logic                    write_hit;

    // register 0 never takes a write and keeps its reset zero
    assign write_hit = r_clk_enable && write_control && (write_reg != '0);

    always_ff @(posedge r_clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write_hit) begin
            registers[write_reg] <= write_data;
        end
    end

    // combinational reads see a same-edge write on the next cycle
    assign read_data1 = registers[read_reg1];
    assign read_data2 = registers[read_reg2];

    // a write aimed at r0 must leave it reading zero afterwards
    a_r0_zero: assert property (@(posedge r_clk) disable iff (reset)
        (read_reg1 == '0) |-> (read_data1 == '0) && $past(registers[0] == '0));

endmodule

// File: verilog/alu_writeback.sv
`timescale 1ns/10ps
`include "mips_exec_macros.svh"

module alu_writeback (
    input  logic                        r_clk,
    input  logic                        reset,
    input  mips_exec_pkg::issue_t       issue,
    input  logic                        issue_valid,
    output logic                        issue_ready,
    input  logic [`MIPS_DATA_W-1:0]     rs_data,
    input  logic [`MIPS_DATA_W-1:0]     rt_data,
    output logic                        wb_en,
    output logic [`MIPS_ADDR_W-1:0]     wb_addr,
    output logic [`MIPS_DATA_W-1:0]     wb_data,
    output mips_exec_pkg::wb_result_t   result,
    output logic                        result_valid,
    input  logic                        result_ready
);
    import mips_exec_pkg::*;

    logic [`MIPS_DATA_W-1:0] op_a;
    logic [`MIPS_DATA_W-1:0] op_b;
    logic [`MIPS_DATA_W-1:0] alu_value;
    logic [4:0]              shift_amt;
    logic                    less_signed;
    logic                    accept;

    // operand select
    assign op_a        = rs_data;
    assign op_b        = issue.use_imm ? issue.imm : rt_data;
    assign shift_amt   = issue.imm[4:0];
    assign less_signed = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (issue.op)
            OP_ADDU, OP_ADDIU: alu_value = op_a + op_b;
            OP_SUBU:           alu_value = op_a - op_b;
            OP_AND, OP_ANDI:   alu_value = op_a & op_b;
            OP_OR, OP_ORI:     alu_value = op_a | op_b;
            OP_XOR, OP_XORI:   alu_value = op_a ^ op_b;
            OP_SLT, OP_SLTI:   alu_value = {{(`MIPS_DATA_W-1){1'b0}}, less_signed};
            // shifts act on rt by shamt
            OP_SLL:            alu_value = rt_data << shift_amt;
            OP_SRL:            alu_value = rt_data >> shift_amt;
            // already shifted up in the decoder
            OP_LUI:            alu_value = op_b;
            default:           alu_value = '0;
        endcase
        if (issue.illegal) begin
            alu_value = '0;
        end
    end

    // output slot empty or draining this cycle
    assign issue_ready = !result_valid || result_ready;
    assign accept      = issue_valid && issue_ready;

    // write-back lands on the same edge as the output record
    assign wb_en   = accept && !issue.illegal;
    assign wb_addr = issue.dest;
    assign wb_data = alu_value;

    always_ff @(posedge r_clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (accept) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    // output payload
    always_ff @(posedge r_clk) begin
        if (accept) begin
            result.dest    <= issue.dest;
            result.value   <= alu_value;
            result.illegal <= issue.illegal;
        end
    end

    // held record survives a stall untouched
    a_result_stable: assert property (@(posedge r_clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result));

    // an illegal record writes nothing and comes out flagged with value zero
    a_no_illegal_wb: assert property (@(posedge r_clk) disable iff (reset)
        accept && issue.illegal |=> !$past(wb_en) && result.illegal && result.value == '0);

endmodule

// File: verilog/mips_exec_top.sv
`timescale 1ns/10ps
`include "mips_exec_macros.svh"

module mips_exec_top (
    input  logic                       r_clk,
    input  logic                       reset,
    input  mips_exec_pkg::instr_word_u instr,
    input  logic                       instr_valid,
    output logic                       instr_ready,
    output mips_exec_pkg::wb_result_t  result,
    output logic                       result_valid,
    input  logic                       result_ready
);
    import mips_exec_pkg::*;

    // decoder to ALU stage
    issue_t                  issue;
    logic                    issue_valid;
    logic                    issue_ready;
    // register file read data
    logic [`MIPS_DATA_W-1:0] rs_data;
    logic [`MIPS_DATA_W-1:0] rt_data;
    // write-back path
    logic                    wb_en;
    logic [`MIPS_ADDR_W-1:0] wb_addr;
    logic [`MIPS_DATA_W-1:0] wb_data;
    // clock enable follows the ALU stage handshake
    wire                     stage_accept = issue_valid & issue_ready;

    instr_decoder u_decoder (
        .r_clk       (r_clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

    // read addresses come straight from the held issue record
    regfile u_regfile (
        .r_clk         (r_clk),
        .reset         (reset),
        .r_clk_enable  (stage_accept),
        .write_control (wb_en),
        .read_reg1     (issue.rs),
        .read_reg2     (issue.rt),
        .write_reg     (wb_addr),
        .write_data    (wb_data),
        .read_data1    (rs_data),
        .read_data2    (rt_data)
    );

    alu_writeback u_alu (
        .r_clk        (r_clk),
        .reset        (reset),
        .issue        (issue),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

// File: testbench/tb_mips_exec_top.sv
`timescale 1ns/10ps

module tb_mips_exec_top;
    import mips_exec_pkg::*;

    // test, instr, dest, value, illegal
    localparam int COLS     = 5;
    localparam int MAX_ROWS = 100;

    // DUT inputs start at known values
    logic        r_clk        = 1'b0;
    logic        reset        = 1'b1;
    instr_word_u instr        = '0;
    logic        instr_valid  = 1'b0;
    logic        result_ready = 1'b0;
    logic        instr_ready;
    wb_result_t  result;
    logic        result_valid;

    // raw pattern words row after row
    logic [31:0] pat_mem [0:511];

    int num_pat      = 0;
    int wr_ptr       = 0;
    int rd_ptr       = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;
    int seed         = 58;
    int err_count    = 0;
    int test_errors  = 0;
    int test_results = 0;
    int test_count   = 0;
    bit timed_out    = 1'b0;

    mips_exec_top dut0 (
        .r_clk        (r_clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    // 20 ns period
    always #10 r_clk = ~r_clk;

    // one column of one pattern row
    function automatic logic [31:0] pat_word(input int row, input int col);
        logic [8:0] addr;
        addr = 9'(row * COLS + col);
        return pat_mem[addr];
    endfunction

    // compare one accepted result with its row
    task automatic check_result(input int row);
        logic [31:0] test_id;
        logic [31:0] exp_dest;
        logic [31:0] exp_value;
        logic [31:0] exp_illegal;
        test_id     = pat_word(row, 0);
        exp_dest    = pat_word(row, 2);
        exp_value   = pat_word(row, 3);
        exp_illegal = pat_word(row, 4);
        test_results++;
        if (result.dest !== exp_dest[4:0]) begin
            $display("error result.dest row %0d: expected %h got %h",
                     row, exp_dest[4:0], result.dest);
            test_errors++;
        end
        if (result.value !== exp_value) begin
            $display("error result.value row %0d: expected %h got %h",
                     row, exp_value, result.value);
            test_errors++;
        end
        if (result.illegal !== exp_illegal[0]) begin
            $display("error result.illegal row %0d: expected %h got %h",
                     row, exp_illegal[0], result.illegal);
            test_errors++;
        end
        // last row of its group closes the test
        if (row == num_pat - 1 || pat_word(row + 1, 0) != test_id) begin
            $display("test %0d: %0d results, %0d errors", test_id, test_results, test_errors);
            err_count    += test_errors;
            test_count++;
            test_errors  = 0;
            test_results = 0;
        end
    endtask

    // back-to-back instruction source advancing on each transfer
    always @(posedge r_clk) begin : drive_instr
        int next_row;
        if (reset) begin
            wr_ptr = 0;
            instr_valid <= 1'b0;
            instr       <= '0;
        end else begin
            next_row = wr_ptr;
            if (instr_valid && instr_ready) begin
                next_row = wr_ptr + 1;
            end
            wr_ptr = next_row;
            if (next_row < num_pat) begin
                instr_valid <= 1'b1;
                instr       <= pat_word(next_row, 1);
            end else begin
                instr_valid <= 1'b0;
                instr       <= '0;
            end
        end
    end

    // sink stalls roughly one cycle in three
    always @(posedge r_clk) begin
        if (reset) begin
            result_ready <= 1'b0;
        end else begin
            result_ready <= ($random(seed) % 3) != 0;
        end
    end

    always @(posedge r_clk) begin
        if (!reset) begin
            cycle_count++;
        end
    end

    // result taken on each completed handshake
    always @(posedge r_clk) begin
        if (!reset && result_valid && result_ready) begin
            if (rd_ptr < num_pat) begin
                check_result(rd_ptr);
                rd_ptr++;
            end else begin
                $display("a result arrived after the last expected one, dest %h value %h",
                         result.dest, result.value);
                err_count++;
            end
        end
    end

    initial begin
        $readmemh("testbench/mips_exec_patterns.txt", pat_mem);
        // test number zero ends the list
        while (num_pat < MAX_ROWS && !$isunknown(pat_word(num_pat, 0))
               && pat_word(num_pat, 0) != 32'h0) begin
            num_pat++;
        end
        cycle_limit = num_pat * 8 + 50;
        if (num_pat == 0) begin
            $display("the pattern file gave no instructions");
            err_count++;
        end
        repeat (3) @(posedge r_clk);
        reset <= 1'b0;
        // idle state right after reset
        @(negedge r_clk);
        if (instr_ready !== 1'b1) begin
            $display("error instr_ready after reset: expected %h got %h", 1'b1, instr_ready);
            err_count++;
        end
        if (result_valid !== 1'b0) begin
            $display("error result_valid after reset: expected %h got %h", 1'b0, result_valid);
            err_count++;
        end
        while (rd_ptr < num_pat && cycle_count < cycle_limit) begin
            @(posedge r_clk);
        end
        if (rd_ptr < num_pat) begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles, only %0d of %0d results came back",
                     cycle_count, rd_ptr, num_pat);
        end else begin
            // room for a stray extra result to show
            repeat (10) @(posedge r_clk);
        end
        $display("done: %0d tests, %0d of %0d results, %0d errors",
                 test_count, rd_ptr, num_pat, err_count);
        if (!timed_out && err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: mips_exec_top.f
+incdir+verilog
verilog/mips_exec_pkg.sv
verilog/instr_decoder.sv
verilog/regfile.sv
verilog/alu_writeback.sv
verilog/mips_exec_top.sv
testbench/tb_mips_exec_top.sv

// File: Makefile
TOP = tb_mips_exec_top

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f mips_exec_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: testbench/mips_exec_patterns.txt
// columns: test number, instruction word, expected dest, expected value, illegal flag
// all hex; a row with test number 00 ends the list

// test 1: R-type ops on r1 and r2 loaded by ori and lui
01 34011234 01 00001234 0  // ori  r1, r0, 0x1234
01 3c028765 02 87650000 0  // lui  r2, 0x8765
01 344200f0 02 876500f0 0  // ori  r2, r2, 0x00f0
01 00221821 03 87651324 0  // addu r3, r1, r2
01 00222023 04 789b1144 0  // subu r4, r1, r2
01 00222824 05 00000030 0  // and  r5, r1, r2
01 00223025 06 876512f4 0  // or   r6, r1, r2
01 00223826 07 876512c4 0  // xor  r7, r1, r2
01 0041402a 08 00000001 0  // slt  r8, r2, r1
01 0022482a 09 00000000 0  // slt  r9, r1, r2
01 00015100 0a 00012340 0  // sll  r10, r1, 4
01 00025a02 0b 00876500 0  // srl  r11, r2, 8

// test 2: immediate extension
02 242cffff 0c 00001233 0  // addiu r12, r1, -1
02 240d8000 0d ffff8000 0  // addiu r13, r0, 0x8000
02 282effff 0e 00000000 0  // slti  r14, r1, -1
02 29af0001 0f 00000001 0  // slti  r15, r13, 1
02 31b0ffff 10 00008000 0  // andi  r16, r13, 0xffff
02 35b18001 11 ffff8001 0  // ori   r17, r13, 0x8001
02 39b2ffff 12 ffff7fff 0  // xori  r18, r13, 0xffff
02 3c13abcd 13 abcd0000 0  // lui   r19, 0xabcd

// test 3: dependent chain, no gaps
03 24140005 14 00000005 0  // addiu r20, r0, 5
03 0294a021 14 0000000a 0  // addu  r20, r20, r20
03 26940007 14 00000011 0  // addiu r20, r20, 7
03 0014a080 14 00000044 0  // sll   r20, r20, 2
03 0281a823 15 ffffee10 0  // subu  r21, r20, r1
03 3ab500ff 15 ffffeeef 0  // xori  r21, r21, 0xff

// test 4: r0 ignores writes
04 34005555 00 00005555 0  // ori   r0, r0, 0x5555
04 0001b021 16 00001234 0  // addu  r22, r0, r1
04 24200001 00 00001235 0  // addiu r0, r1, 1
04 0040b821 17 876500f0 0  // addu  r23, r2, r0

// test 5: illegal opcode and funct leave r24 alone
05 34180abc 18 00000abc 0  // ori   r24, r0, 0xabc
05 20381111 18 00000000 1  // opcode 0x08
05 0022c020 18 00000000 1  // funct 0x20
05 0300c825 19 00000abc 0  // or    r25, r24, r0

// test 6: mixed stream under output stalls
06 241a0100 1a 00000100 0  // addiu r26, r0, 0x100
06 275a0001 1a 00000101 0  // addiu r26, r26, 1
06 275a0001 1a 00000102 0  // addiu r26, r26, 1
06 275a0001 1a 00000103 0  // addiu r26, r26, 1
06 0353d825 1b abcd0103 0  // or    r27, r26, r19
06 001be402 1c 0000abcd 0  // srl   r28, r27, 16
06 039ae82a 1d 00000000 0  // slt   r29, r28, r26
06 035cf023 1e ffff5536 0  // subu  r30, r26, r28

// end of list
00 00000000 00 00000000 0
